/* hdl/trig_pkg.sv */
// acquisition state and trigger type enums, adc sample type and triggerer configuration struct
package trig_pkg;

	// acquisition states, encodings follow the readout software
	typedef enum logic [7:0] {
		st_ready     = 8'd0,   // idle, ram writing stopped
		st_arm       = 8'd1,   // edge trigger first step
		st_fire      = 8'd2,   // edge trigger second step
		st_wait_lvds = 8'd5,   // waiting on a neighbour board
		st_force     = 8'd6,   // auto trigger
		st_wait_ext  = 8'd7,   // waiting on back panel input
		st_prefill   = 8'd249, // pre-trigger samples
		st_post      = 8'd250, // triggered, taking post-trigger samples
		st_hold      = 8'd251  // waiting for readout
	} acq_state_t;

	typedef enum logic [7:0] {
		trig_off     = 8'd0, // conditional triggering disabled
		trig_rising  = 8'd1,
		trig_falling = 8'd2,
		trig_lvds    = 8'd3, // from another board
		trig_auto    = 8'd4, // forced capture
		trig_ext     = 8'd5  // back panel sma
	} trig_type_t;

	typedef logic signed [11:0] sample_t; // one adc sample

	typedef struct packed {
		sample_t      lower_thresh;
		sample_t      upper_thresh;
		logic [15:0]  post_length;  // takes after the trigger
		logic [15:0]  pre_length;   // takes before arming
		trig_type_t   trig_type;
		logic [7:0]   tot_length;   // time over threshold in takes
		logic [7:0]   merging;      // ticks merged per take
		logic [4:0]   downsample;   // divider is 2**downsample
	} trig_cfg_t;

endpackage

/* hdl/acq_pacer.sv */
// downsample divider, merging counter, take pulse, ram write strobe and wrapping write address
`timescale 1ns/1ps

module acq_pacer #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                  clklvds,
	input  logic                  rstn,
	input  logic                  run,            // high while acquiring
	input  trig_pkg::trig_cfg_t   cfg,
	output logic                  take,           // committed sample this cycle
	output logic [7:0]            merge_count,
	output logic                  ram_wr,
	output logic [ADDR_WIDTH-1:0] ram_wr_address
);

	logic [31:0] div_count; // counts from one, tick when bit downsample is set
	logic        tick;      // divider tick

	assign tick = div_count[cfg.downsample];
	assign take = run && tick && (merge_count == cfg.merging);

	// divider and merging counter
	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			div_count <= 32'd1;
			merge_count <= 8'd1;
		end else if (!run) begin
			div_count <= 32'd1; // reload while stopped
			merge_count <= 8'd1;
		end else if (tick) begin
			div_count <= 32'd1;
			if (merge_count == cfg.merging) begin
				merge_count <= 8'd1; // this tick was a take
			end else begin
				merge_count <= merge_count + 8'd1;
			end
		end else begin
			div_count <= div_count + 32'd1;
		end
	end

	// write strobe and address move together one cycle after the take
	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			ram_wr <= 1'b0;
			ram_wr_address <= '0;
		end else begin
			ram_wr <= take;
			if (take) begin
				ram_wr_address <= ram_wr_address + ADDR_WIDTH'(1); // wraps at the ram end
			end
		end
	end

	// only full rate pacing may keep ram_wr high for two cycles in a row
	a_wr_single_pulse: assert property (@(posedge clklvds) disable iff (!rstn)
		ram_wr && (cfg.downsample != 5'd0 || cfg.merging != 8'd1) |=> !ram_wr);

endmodule

/* hdl/edge_detector.sv */
// threshold comparison over one clock's sample group, registered arm and fire hits
`timescale 1ns/1ps

module edge_detector #(
	parameter int NUM_SAMPLES = 10
) (
	input  logic                                 clklvds,
	input  logic                                 rstn,
	input  trig_pkg::sample_t [NUM_SAMPLES-1:0]  samples,
	input  trig_pkg::trig_cfg_t                  cfg,
	input  logic                                 rising,   // polarity latched by the fsm
	output logic                                 arm_hit,  // first step seen in this group
	output logic                                 fire_hit  // second step seen in this group
);

	logic [NUM_SAMPLES-1:0] below; // per sample, under lower_thresh
	logic [NUM_SAMPLES-1:0] above; // per sample, over upper_thresh
	logic                   below_any;
	logic                   above_any;

	// signed compare of every sample against both thresholds
	for (genvar g = 0; g < NUM_SAMPLES; g++) begin : g_cmp
		assign below[g] = samples[g] < cfg.lower_thresh;
		assign above[g] = samples[g] > cfg.upper_thresh;
	end

	assign below_any = |below;
	assign above_any = |above;

	// rising arms low and fires high, falling swaps the two
	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			arm_hit <= 1'b0;
			fire_hit <= 1'b0;
		end else begin
			arm_hit <= rising ? below_any : above_any;
			fire_hit <= rising ? above_any : below_any;
		end
	end

endmodule

/* hdl/trig_fsm.sv */
// acquisition fsm with config register, pre/post take counter, time-over-threshold counter, lvds outputs
`timescale 1ns/1ps

module trig_fsm (
	input  logic                  clklvds,
	input  logic                  rstn,
	input  trig_pkg::trig_cfg_t   cfg,
	input  logic                  trigger_live,   // readout allows arming
	input  logic                  did_readout,
	input  logic                  lvds_trig_in,   // from the board before
	input  logic                  lvds_trig_b_in, // from the board after
	input  logic                  ext_trig_in,
	input  logic                  take,
	input  logic                  arm_hit,
	input  logic                  fire_hit,
	output trig_pkg::trig_cfg_t   cfg_q,          // registered config for all blocks
	output logic                  run,
	output logic                  rising,
	output logic                  trig_strobe,    // first cycle of st_post
	output logic                  done_strobe,    // first cycle of st_hold
	output logic                  lvds_trig_out,
	output logic                  lvds_trig_b_out,
	output logic                  aux_trig,
	output trig_pkg::acq_state_t  acq_state
);

	trig_pkg::trig_type_t active_type;  // type latched at ready
	logic [15:0]          take_cnt;     // shared pre and post take counter
	logic [7:0]           tot_cnt;      // takes spent over threshold
	logic                 type_changed;
	logic                 post_done;    // post count reached
	logic                 fire_now;     // trigger decided this cycle
	logic                 fwd_only;     // lvds trigger came forwards only

	assign type_changed = cfg_q.trig_type != active_type;
	assign post_done = (acq_state == trig_pkg::st_post) && (take_cnt >= cfg_q.post_length);
	assign fwd_only = (active_type == trig_pkg::trig_lvds) && !lvds_trig_b_in;

	// run drops with the last post take so st_hold sees no write
	assign run = (acq_state != trig_pkg::st_ready) && (acq_state != trig_pkg::st_hold) &&
		!post_done;
	assign aux_trig = acq_state == trig_pkg::st_post; // back panel trigger out

	// trigger decision for every source
	always_comb begin
		case (acq_state)
			trig_pkg::st_fire:
				fire_now = !type_changed && fire_hit && (tot_cnt >= cfg_q.tot_length);
			trig_pkg::st_wait_lvds:
				fire_now = !type_changed && (lvds_trig_in || lvds_trig_b_in);
			trig_pkg::st_force:
				fire_now = 1'b1; // one cycle after entry
			trig_pkg::st_wait_ext:
				fire_now = !type_changed && ext_trig_in;
			default:
				fire_now = 1'b0;
		endcase
	end

	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			cfg_q <= '0;
			acq_state <= trig_pkg::st_ready;
			active_type <= trig_pkg::trig_off;
			rising <= 1'b0;
			take_cnt <= '0;
			tot_cnt <= '0;
			trig_strobe <= 1'b0;
			done_strobe <= 1'b0;
			lvds_trig_out <= 1'b0;
			lvds_trig_b_out <= 1'b0;
		end else begin
			cfg_q <= cfg; // config is already in the clklvds domain
			trig_strobe <= 1'b0;
			done_strobe <= 1'b0;
			if (!trig_strobe) begin // keep lvds up through the strobe cycle, two cycles total
				lvds_trig_out <= 1'b0;
				lvds_trig_b_out <= 1'b0;
			end
			if (fire_now) begin
				acq_state <= trig_pkg::st_post;
				take_cnt <= '0; // now counts post takes
				trig_strobe <= 1'b1;
				lvds_trig_out <= 1'b1; // tell the others forwards
				lvds_trig_b_out <= !fwd_only; // and backwards unless it came forwards
			end else begin
				case (acq_state)
					trig_pkg::st_ready: begin
						active_type <= cfg_q.trig_type;
						rising <= cfg_q.trig_type == trig_pkg::trig_rising; // settles before arm
						take_cnt <= '0;
						tot_cnt <= '0;
						if (cfg_q.trig_type != trig_pkg::trig_off) begin
							acq_state <= trig_pkg::st_prefill;
						end
					end
					trig_pkg::st_prefill: begin
						if (type_changed) begin
							acq_state <= trig_pkg::st_ready;
						end else if (take_cnt < cfg_q.pre_length) begin
							if (take) begin
								take_cnt <= take_cnt + 16'd1;
							end
						end else if (trigger_live) begin
							take_cnt <= '0;
							case (active_type)
								trig_pkg::trig_rising:  acq_state <= trig_pkg::st_arm;
								trig_pkg::trig_falling: acq_state <= trig_pkg::st_arm;
								trig_pkg::trig_lvds:    acq_state <= trig_pkg::st_wait_lvds;
								trig_pkg::trig_auto:    acq_state <= trig_pkg::st_force;
								trig_pkg::trig_ext:     acq_state <= trig_pkg::st_wait_ext;
								default:                acq_state <= trig_pkg::st_ready;
							endcase
						end
					end
					trig_pkg::st_arm: begin
						if (type_changed) begin
							acq_state <= trig_pkg::st_ready;
						end else if (arm_hit) begin
							acq_state <= trig_pkg::st_fire; // first step met
						end
					end
					trig_pkg::st_fire: begin
						if (type_changed) begin
							acq_state <= trig_pkg::st_ready;
						end else if (fire_hit && take) begin
							tot_cnt <= tot_cnt + 8'd1; // still over threshold
						end
					end
					trig_pkg::st_wait_lvds, trig_pkg::st_wait_ext: begin
						if (type_changed) begin
							acq_state <= trig_pkg::st_ready;
						end
					end
					trig_pkg::st_post: begin
						if (post_done) begin
							acq_state <= trig_pkg::st_hold;
							done_strobe <= 1'b1;
						end else if (take) begin
							take_cnt <= take_cnt + 16'd1;
						end
					end
					trig_pkg::st_hold: begin
						take_cnt <= '0;
						if (did_readout) begin
							acq_state <= trig_pkg::st_ready;
						end
					end
					default: acq_state <= trig_pkg::st_ready;
				endcase
			end
		end
	end

	// neighbours see a two cycle pulse and never a stuck line
	a_lvds_two_cycles: assert property (@(posedge clklvds) disable iff (!rstn)
		lvds_trig_out [*2] |=> !lvds_trig_out);

	// the recorder latches only on the first post cycle
	a_strobe_on_entry: assert property (@(posedge clklvds) disable iff (!rstn)
		trig_strobe |-> (acq_state == trig_pkg::st_post) &&
			($past(acq_state) != trig_pkg::st_post));

endmodule

/* hdl/trig_recorder.sv */
// trigger address and merge count latch, completed event counter
`timescale 1ns/1ps

module trig_recorder #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                  clklvds,
	input  logic                  rstn,
	input  logic                  trig_strobe,      // entry to st_post
	input  logic                  done_strobe,      // entry to st_hold
	input  trig_pkg::trig_cfg_t   cfg,
	input  logic [ADDR_WIDTH-1:0] ram_wr_address,
	input  logic [7:0]            merge_count,
	output logic [ADDR_WIDTH-1:0] trig_address,     // where the edge started in ram
	output logic [7:0]            trig_merge_count,
	output logic [31:0]           event_count
);

	// back off by the time spent over threshold
	always_ff @(posedge clklvds) begin
		if (trig_strobe) begin
			trig_address <= ram_wr_address - ADDR_WIDTH'(cfg.tot_length);
			trig_merge_count <= merge_count; // merge phase at the trigger
		end
	end

	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			event_count <= 32'd0;
		end else if (done_strobe) begin
			event_count <= event_count + 32'd1; // one per completed capture
		end
	end

	// a capture cannot start and finish in the same cycle
	a_strobes_apart: assert property (@(posedge clklvds) disable iff (!rstn)
		!(trig_strobe && done_strobe));

endmodule

/* hdl/triggerer_top.sv */
// triggerer top level, pacer, edge detector, fsm and recorder instances
`timescale 1ns/1ps

module triggerer_top #(
	parameter int NUM_SAMPLES = 10, // samples per clock
	parameter int ADDR_WIDTH  = 10  // ram depth is 2**ADDR_WIDTH
) (
	input  logic                                 clklvds,
	input  logic                                 rstn,
	input  trig_pkg::sample_t [NUM_SAMPLES-1:0]  samples,
	input  trig_pkg::trig_cfg_t                  cfg,
	input  logic                                 trigger_live,
	input  logic                                 did_readout,
	input  logic                                 lvds_trig_in,
	input  logic                                 lvds_trig_b_in,
	input  logic                                 ext_trig_in,
	output logic                                 ram_wr,
	output logic [ADDR_WIDTH-1:0]                ram_wr_address,
	output logic                                 lvds_trig_out,
	output logic                                 lvds_trig_b_out,
	output logic                                 aux_trig,
	output trig_pkg::acq_state_t                 acq_state,
	output logic [31:0]                          event_count,
	output logic [ADDR_WIDTH-1:0]                trig_address,
	output logic [7:0]                           trig_merge_count
);

	trig_pkg::trig_cfg_t cfg_q;        // registered config from the fsm
	logic                run;
	logic                rising;
	logic                take;
	logic [7:0]          merge_count;
	logic                arm_hit;
	logic                fire_hit;
	logic                trig_strobe;
	logic                done_strobe;

	acq_pacer #(
		.ADDR_WIDTH     (ADDR_WIDTH)
	) u_pacer (
		.clklvds        (clklvds),
		.rstn           (rstn),
		.run            (run),
		.cfg            (cfg_q),
		.take           (take),
		.merge_count    (merge_count),
		.ram_wr         (ram_wr),
		.ram_wr_address (ram_wr_address)
	);

	edge_detector #(
		.NUM_SAMPLES    (NUM_SAMPLES)
	) u_edge (
		.clklvds        (clklvds),
		.rstn           (rstn),
		.samples        (samples),
		.cfg            (cfg_q),
		.rising         (rising),
		.arm_hit        (arm_hit),
		.fire_hit       (fire_hit)
	);

	trig_fsm u_fsm (
		.clklvds         (clklvds),
		.rstn            (rstn),
		.cfg             (cfg),
		.trigger_live    (trigger_live),
		.did_readout     (did_readout),
		.lvds_trig_in    (lvds_trig_in),
		.lvds_trig_b_in  (lvds_trig_b_in),
		.ext_trig_in     (ext_trig_in),
		.take            (take),
		.arm_hit         (arm_hit),
		.fire_hit        (fire_hit),
		.cfg_q           (cfg_q),
		.run             (run),
		.rising          (rising),
		.trig_strobe     (trig_strobe),
		.done_strobe     (done_strobe),
		.lvds_trig_out   (lvds_trig_out),
		.lvds_trig_b_out (lvds_trig_b_out),
		.aux_trig        (aux_trig),
		.acq_state       (acq_state)
	);

	trig_recorder #(
		.ADDR_WIDTH       (ADDR_WIDTH)
	) u_recorder (
		.clklvds          (clklvds),
		.rstn             (rstn),
		.trig_strobe      (trig_strobe),
		.done_strobe      (done_strobe),
		.cfg              (cfg_q),
		.ram_wr_address   (ram_wr_address),
		.merge_count      (merge_count),
		.trig_address     (trig_address),
		.trig_merge_count (trig_merge_count),
		.event_count      (event_count)
	);

endmodule

/* tb/tb_triggerer.sv */
// triggerer testbench with clock, reset, lfsr stimulus, directed test tasks and summary line
`timescale 1ns/1ps

module tb_triggerer;

	localparam int NUM_SAMPLES = 10;
	localparam int ADDR_WIDTH  = 10;
	localparam int in_band     = 0; // sample folds
	localparam int below_lower = 1;
	localparam int above_upper = 2;

	logic                                 clklvds;
	logic                                 rstn;
	trig_pkg::sample_t [NUM_SAMPLES-1:0]  samples;
	trig_pkg::trig_cfg_t                  cfg;
	logic                                 trigger_live;
	logic                                 did_readout;
	logic                                 lvds_trig_in;
	logic                                 lvds_trig_b_in;
	logic                                 ext_trig_in;
	logic                                 ram_wr;
	logic [ADDR_WIDTH-1:0]                ram_wr_address;
	logic                                 lvds_trig_out;
	logic                                 lvds_trig_b_out;
	logic                                 aux_trig;
	trig_pkg::acq_state_t                 acq_state;
	logic [31:0]                          event_count;
	logic [ADDR_WIDTH-1:0]                trig_address;
	logic [7:0]                           trig_merge_count;

	logic [15:0] lfsr = 16'd99; // stimulus seed
	int          checks = 0;
	int          errors = 0;

	triggerer_top #(
		.NUM_SAMPLES      (NUM_SAMPLES),
		.ADDR_WIDTH       (ADDR_WIDTH)
	) u_dut (
		.clklvds          (clklvds),
		.rstn             (rstn),
		.samples          (samples),
		.cfg              (cfg),
		.trigger_live     (trigger_live),
		.did_readout      (did_readout),
		.lvds_trig_in     (lvds_trig_in),
		.lvds_trig_b_in   (lvds_trig_b_in),
		.ext_trig_in      (ext_trig_in),
		.ram_wr           (ram_wr),
		.ram_wr_address   (ram_wr_address),
		.lvds_trig_out    (lvds_trig_out),
		.lvds_trig_b_out  (lvds_trig_b_out),
		.aux_trig         (aux_trig),
		.acq_state        (acq_state),
		.event_count      (event_count),
		.trig_address     (trig_address),
		.trig_merge_count (trig_merge_count)
	);

	always #4 clklvds = ~clklvds; // 8 ns period

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// whole group inside the band, or all under lower / over upper
	task automatic set_samples(input int kind);
		int v;
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			case (kind)
				below_lower: v = -300 - int'(rand_bits(10));
				above_upper: v = 300 + int'(rand_bits(10));
				default:     v = int'(rand_bits(8)) % 200 - 100;
			endcase
			samples[i] = trig_pkg::sample_t'(v);
		end
	endtask

	task automatic set_cfg(input trig_pkg::trig_type_t t, input int ds, input int merging,
		input int pre, input int post, input int tot);
		cfg.trig_type = t;
		cfg.downsample = 5'(ds);
		cfg.merging = 8'(merging);
		cfg.pre_length = 16'(pre);
		cfg.post_length = 16'(post);
		cfg.tot_length = 8'(tot);
	endtask

	task automatic wait_state(input trig_pkg::acq_state_t target, input int limit);
		int n;
		for (n = 0; n < limit && acq_state != target; n++) begin
			@(negedge clklvds);
		end
		checks++;
		assert (acq_state == target) else begin
			errors++;
			$display("timed out waiting for state %s, still in %s", target.name(), acq_state.name());
		end
	endtask

	// counts lvds pulse cycles and post cycles until st_hold
	task automatic count_trig_pulses(output int n_out, output int n_b, output int n_post);
		logic trig_seen; // lvds pulse started, capture under way
		n_out = 0;
		n_b = 0;
		n_post = 0;
		trig_seen = 1'b0;
		for (int t = 0; t < 500 && acq_state != trig_pkg::st_hold; t++) begin
			trig_seen |= lvds_trig_out;
			n_out += int'(lvds_trig_out);
			n_b += int'(lvds_trig_b_out);
			n_post += int'(acq_state == trig_pkg::st_post);
			check_val("aux_trig", aux_trig, trig_seen); // up from the trigger until hold
			@(negedge clklvds);
		end
		wait_state(trig_pkg::st_hold, 1); // reports the timeout if hold never came
		check_val("aux_trig in hold", aux_trig, 0);
	endtask

	task automatic release_hold(input logic [31:0] ev_before);
		cfg.trig_type = trig_pkg::trig_off; // stay in ready afterwards
		did_readout = 1'b1;
		wait_state(trig_pkg::st_ready, 20);
		did_readout = 1'b0;
		check_val("event_count", event_count, ev_before + 32'd1);
	endtask

	task automatic test_pacing();
		int n_wr;
		logic [ADDR_WIDTH-1:0] addr0;
		set_cfg(trig_pkg::trig_auto, 1, 2, 1000, 16, 0); // long prefill keeps it writing
		wait_state(trig_pkg::st_prefill, 20);
		addr0 = ram_wr_address;
		n_wr = 0;
		repeat (400) begin
			@(negedge clklvds);
			n_wr += int'(ram_wr);
		end
		checks++;
		assert (n_wr >= 400 / 4 - 1 && n_wr <= 400 / 4 + 1) else begin // 2**1 * 2 per write
			errors++;
			$display("CHECK FAILED at %0t: ram_wr count got %0d expected %0d", $time, n_wr, 100);
		end
		check_val("ram_wr_address", ram_wr_address, addr0 + ADDR_WIDTH'(n_wr));
		cfg.trig_type = trig_pkg::trig_off; // abort the prefill
		wait_state(trig_pkg::st_ready, 20);
	endtask

	task automatic test_auto();
		int n_out;
		int n_b;
		int n_post;
		logic [31:0] ev0;
		ev0 = event_count;
		trigger_live = 1'b1;
		set_cfg(trig_pkg::trig_auto, 0, 1, 8, 16, 0);
		count_trig_pulses(n_out, n_b, n_post);
		check_val("lvds_trig_out cycles", n_out, 2);
		check_val("lvds_trig_b_out cycles", n_b, 2);
		check_val("post took enough cycles", n_post >= 16, 1);
		repeat (10) begin
			check_val("ram_wr in hold", ram_wr, 0);
			@(negedge clklvds);
		end
		check_val("acq_state", acq_state, trig_pkg::st_hold); // no readout yet
		release_hold(ev0);
	endtask

	task automatic test_edge(input trig_pkg::trig_type_t t, input int first, input int second);
		logic [ADDR_WIDTH-1:0] addr_at;
		logic                  wr_at;
		logic [31:0] ev0;
		ev0 = event_count;
		set_samples(in_band);
		set_cfg(t, 0, 2, 4, 8, 0);
		wait_state(trig_pkg::st_arm, 100);
		set_samples(first);
		wait_state(trig_pkg::st_fire, 20);
		set_samples(second);
		wait_state(trig_pkg::st_post, 20);
		addr_at = ram_wr_address; // address on the trigger cycle
		wr_at = ram_wr;           // merge count restarts at 1 right after each write
		@(negedge clklvds);
		set_samples(in_band);
		check_val("trig_address", trig_address, addr_at - ADDR_WIDTH'(cfg.tot_length));
		check_val("trig_merge_count", trig_merge_count, wr_at ? 1 : 2);
		wait_state(trig_pkg::st_hold, 100);
		release_hold(ev0);
	endtask

	task automatic test_wrong_polarity();
		int bad;
		set_samples(in_band);
		set_cfg(trig_pkg::trig_rising, 0, 1, 4, 8, 0);
		wait_state(trig_pkg::st_arm, 100);
		set_samples(above_upper); // fire level without the arm step
		bad = 0;
		for (int t = 0; t < 200; t++) begin
			@(negedge clklvds);
			bad += int'(acq_state != trig_pkg::st_arm || lvds_trig_out || lvds_trig_b_out);
		end
		check_val("cycles off st_arm or with lvds out", bad, 0);
		cfg.trig_type = trig_pkg::trig_off;
		set_samples(in_band);
		wait_state(trig_pkg::st_ready, 20);
	endtask

	task automatic test_remote(input trig_pkg::trig_type_t t, input int exp_b);
		int n_out;
		int n_b;
		int n_post;
		logic [31:0] ev0;
		ev0 = event_count;
		set_cfg(t, 0, 1, 4, 8, 0);
		wait_state(t == trig_pkg::trig_lvds ? trig_pkg::st_wait_lvds : trig_pkg::st_wait_ext, 100);
		lvds_trig_in = t == trig_pkg::trig_lvds; // forward only
		ext_trig_in = t == trig_pkg::trig_ext;
		@(negedge clklvds);
		lvds_trig_in = 1'b0;
		ext_trig_in = 1'b0;
		count_trig_pulses(n_out, n_b, n_post);
		check_val("lvds_trig_out cycles", n_out, 2);
		check_val("lvds_trig_b_out cycles", n_b, exp_b);
		release_hold(ev0);
	endtask

	task automatic test_type_change();
		logic [31:0] ev0;
		ev0 = event_count;
		set_cfg(trig_pkg::trig_ext, 0, 1, 4, 8, 0);
		wait_state(trig_pkg::st_wait_ext, 100);
		cfg.trig_type = trig_pkg::trig_rising; // abort while waiting
		wait_state(trig_pkg::st_ready, 20);
		check_val("event_count", event_count, ev0);
		check_val("lvds_trig_out", lvds_trig_out, 0);
		cfg.trig_type = trig_pkg::trig_off;
		repeat (4) @(negedge clklvds);
		check_val("acq_state", acq_state, trig_pkg::st_ready);
	endtask

	initial begin
		clklvds = 1'b0;
		rstn = 1'b0;
		samples = '0;
		cfg = '0;
		cfg.lower_thresh = -12'sd200;
		cfg.upper_thresh = 12'sd200;
		trigger_live = 1'b0;
		did_readout = 1'b0;
		lvds_trig_in = 1'b0;
		lvds_trig_b_in = 1'b0;
		ext_trig_in = 1'b0;
		repeat (5) @(negedge clklvds);
		rstn = 1'b1;
		@(negedge clklvds);
		check_val("ram_wr", ram_wr, 0); // idle after reset
		check_val("aux_trig", aux_trig, 0);
		check_val("lvds_trig_out", lvds_trig_out, 0);
		check_val("acq_state", acq_state, trig_pkg::st_ready);
		check_val("event_count", event_count, 0);
		test_pacing();
		test_auto();
		test_edge(trig_pkg::trig_rising, below_lower, above_upper);
		test_edge(trig_pkg::trig_falling, above_upper, below_lower);
		test_wrong_polarity();
		test_remote(trig_pkg::trig_lvds, 0);
		test_remote(trig_pkg::trig_ext, 2);
		test_type_change();
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* build.f */
hdl/trig_pkg.sv
hdl/acq_pacer.sv
hdl/edge_detector.sv
hdl/trig_fsm.sv
hdl/trig_recorder.sv
hdl/triggerer_top.sv
tb/tb_triggerer.sv
